/* source/icache_macros.svh */
// Instruction cache geometry and bus width constants

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Physical address width
`define ICACHE_AW         32

// Fetch word and bus beat width
`define ICACHE_DW         32

// log2 of line bytes, 16 byte lines
`define ICACHE_P_LINE     4

// log2 of set count
`define ICACHE_P_SETS     4

// log2 of way count
`define ICACHE_P_WAYS     2

// log2 of word bytes
`define ICACHE_WORD_LOG2  2

// Derived counts
`define ICACHE_WAYS       (1 << `ICACHE_P_WAYS)
`define ICACHE_SETS       (1 << `ICACHE_P_SETS)
`define ICACHE_WORDS      (1 << (`ICACHE_P_LINE - `ICACHE_WORD_LOG2))

// Lowest address bit of the tag
`define ICACHE_TAG_LSB    (`ICACHE_P_LINE + `ICACHE_P_SETS)

`endif

/* source/icache_pkg.sv */
// Instruction cache types shared by the cache blocks and the bus side

`include "icache_macros.svh"

package icache_pkg;

   // Plain vectors with a meaning
   typedef logic [`ICACHE_AW-1:0]                       paddr_t;
   typedef logic [`ICACHE_DW-1:0]                       word_t;
   typedef logic [`ICACHE_P_SETS-1:0]                   set_idx_t;
   typedef logic [`ICACHE_AW-`ICACHE_TAG_LSB-1:0]       tag_addr_t;
   typedef logic [`ICACHE_P_WAYS-1:0]                   way_idx_t;
   // 3 is most recently used, 0 is the victim
   typedef logic [`ICACHE_P_WAYS-1:0]                   lru_rank_t;
   typedef logic [`ICACHE_P_LINE-`ICACHE_WORD_LOG2-1:0] beat_cnt_t;
   typedef logic [`ICACHE_WAYS-1:0]                     way_vec_t;

   typedef struct packed {
      logic       valid;
      tag_addr_t  tag;
   } tag_entry_t;

   // Burst read request, len is beats minus one
   typedef struct packed {
      logic       valid;
      paddr_t     addr;
      beat_cnt_t  len;
   } bus_req_t;

   typedef struct packed {
      logic       valid;
      word_t      data;
   } bus_beat_t;

   typedef struct packed {
      logic       valid;
      paddr_t     addr;
   } fetch_req_t;

   typedef enum logic [1:0] {
      S_IDLE  = 2'b00,
      S_FILL  = 2'b01,
      S_RETAG = 2'b11,
      S_BOOT  = 2'b10
   } ctrl_state_t;

endpackage

/* source/icache_tag_store.sv */
// Instruction cache tag store holding valid, tag and LRU rank per way and set

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_tag_store (
   input  logic                                          clk,
   input  logic                                          ibus_rst_n,
   // Read port
   input  logic                                          rd_en,
   input  icache_pkg::set_idx_t                          rd_set,
   output icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]     rd_tags,
   output icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     rd_ranks,
   // Write port
   input  icache_pkg::way_vec_t                          tag_we,
   input  icache_pkg::tag_entry_t                        tag_wr,
   input  logic                                          rank_we,
   input  icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     rank_wr,
   input  icache_pkg::set_idx_t                          wr_set
);

   icache_pkg::tag_entry_t tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
   icache_pkg::lru_rank_t  rank_mem [`ICACHE_WAYS][`ICACHE_SETS];

   logic same_set;

   assign same_set = (wr_set == rd_set);

   ////////////////////////////////////////
   // Array writes
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (tag_we[w])
            tag_mem[w][wr_set] <= tag_wr;
         if (rank_we)
            rank_mem[w][wr_set] <= rank_wr[w];
      end
   end

   ////////////////////////////////////////
   // Registered read with write bypass
   ////////////////////////////////////////

   // A write to the set being read shows up in the read result
   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
      begin
         rd_tags  <= '0;
         rd_ranks <= '0;
      end
      else if (rd_en)
      begin
         for (int w = 0; w < `ICACHE_WAYS; w++)
         begin
            if (tag_we[w] && same_set)
               rd_tags[w] <= tag_wr;
            else
               rd_tags[w] <= tag_mem[w][rd_set];

            if (rank_we && same_set)
               rd_ranks[w] <= rank_wr[w];
            else
               rd_ranks[w] <= rank_mem[w][rd_set];
         end
      end
   end

endmodule

/* source/icache_way_select.sv */
// Instruction cache way selection for hit detection, victim choice and LRU update

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_way_select (
   input  icache_pkg::paddr_t                            req_addr,
   input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]     tags,
   input  icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     ranks,
   output logic                                          hit,
   output icache_pkg::way_idx_t                          hit_way,
   output icache_pkg::way_idx_t                          victim_way,
   output icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     next_ranks
);

   icache_pkg::tag_addr_t  req_tag;
   icache_pkg::way_vec_t   match;
   icache_pkg::lru_rank_t  hit_rank;

   assign req_tag = req_addr[`ICACHE_AW-1:`ICACHE_TAG_LSB];

   // Tag compare per way
   always_comb
   begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
         match[w] = tags[w].valid && (tags[w].tag == req_tag);
   end

   assign hit = |match;

   // At most one way matches, so OR of the indices encodes it
   always_comb
   begin
      hit_way = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (match[w])
            hit_way = hit_way | icache_pkg::way_idx_t'(w);
      end
   end

   // Ranks form a permutation, exactly one way sits at rank 0
   always_comb
   begin
      victim_way = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (ranks[w] == '0)
            victim_way = icache_pkg::way_idx_t'(w);
      end
   end

   assign hit_rank = ranks[hit_way];

   ////////////////////////////////////////
   // Rank update after a hit
   ////////////////////////////////////////

   // Hit way moves to the top, ways above its old rank slide down
   always_comb
   begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (match[w])
            next_ranks[w] = '1;
         else
            next_ranks[w] = ranks[w] - icache_pkg::lru_rank_t'(ranks[w] > hit_rank);
      end
   end

endmodule

/* source/icache_data_store.sv */
// Instruction cache line storage with a registered read and a refill write port

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_data_store (
   input  logic                                      clk,
   // Lookup read, one word from every way
   input  logic                                      rd_en,
   input  icache_pkg::set_idx_t                      rd_set,
   input  icache_pkg::beat_cnt_t                     rd_word,
   output icache_pkg::word_t [`ICACHE_WAYS-1:0]      rd_data,
   // Refill write, one beat at a time
   input  logic                                      wr_en,
   input  icache_pkg::way_idx_t                      wr_way,
   input  icache_pkg::set_idx_t                      wr_set,
   input  icache_pkg::beat_cnt_t                     wr_word,
   input  icache_pkg::word_t                         wr_data
);

   icache_pkg::word_t line_mem [`ICACHE_WAYS][`ICACHE_SETS][`ICACHE_WORDS];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         line_mem[wr_way][wr_set][wr_word] <= wr_data;
   end

   // Read all ways in parallel, the hit way is picked one cycle later
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         for (int w = 0; w < `ICACHE_WAYS; w++)
            rd_data[w] <= line_mem[w][rd_set][rd_word];
      end
   end

endmodule

/* source/icache_refill.sv */
// Instruction cache controller for the boot sweep, miss handling and burst refill

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_refill (
   input  logic                                          clk,
   input  logic                                          ibus_rst_n,
   // Lookup stage
   input  logic                                          req_pending,
   input  icache_pkg::paddr_t                            req_addr,
   input  logic                                          hit,
   input  icache_pkg::way_idx_t                          victim_way,
   input  icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     next_ranks,
   output logic                                          fetch_ready,
   output logic                                          rsp_valid,
   output logic                                          lookup_en,
   // Tag store write port
   output icache_pkg::way_vec_t                          tag_we,
   output icache_pkg::tag_entry_t                        tag_wr,
   output logic                                          rank_we,
   output icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]     rank_wr,
   output icache_pkg::set_idx_t                          wr_set,
   // Data store write port
   output logic                                          data_wr_en,
   output icache_pkg::way_idx_t                          data_wr_way,
   output icache_pkg::beat_cnt_t                         data_wr_word,
   // Instruction bus
   output icache_pkg::bus_req_t                          bus_a,
   input  logic                                          bus_a_ready,
   input  icache_pkg::bus_beat_t                         bus_b
);

   icache_pkg::ctrl_state_t state_q;
   icache_pkg::ctrl_state_t state_d;
   icache_pkg::set_idx_t    boot_set_q;
   icache_pkg::beat_cnt_t   beat_q;
   icache_pkg::way_idx_t    fill_way_q;
   logic                    bus_req_q;
   logic                    in_boot;
   logic                    in_idle;
   logic                    miss;
   logic                    last_beat;

   assign in_boot   = (state_q == icache_pkg::S_BOOT);
   assign in_idle   = (state_q == icache_pkg::S_IDLE);
   assign miss      = in_idle && req_pending && !hit;
   assign last_beat = (state_q == icache_pkg::S_FILL) && bus_b.valid && (beat_q == '1);

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         icache_pkg::S_BOOT:
            if (boot_set_q == '0)
               state_d = icache_pkg::S_IDLE;
         icache_pkg::S_IDLE:
            if (miss)
               state_d = icache_pkg::S_FILL;
         icache_pkg::S_FILL:
            if (last_beat)
               state_d = icache_pkg::S_RETAG;
         default:
            state_d = icache_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
      begin
         state_q    <= icache_pkg::S_BOOT;
         boot_set_q <= '1;
         beat_q     <= '0;
         bus_req_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // Sweep runs from the top set down to set 0
         if (in_boot)
            boot_set_q <= boot_set_q - 1'b1;
         if (data_wr_en)
            beat_q <= beat_q + 1'b1;
         if (miss)
            bus_req_q <= 1'b1;
         else if (bus_req_q && bus_a_ready)
            bus_req_q <= 1'b0;
      end
   end

   // Victim is fixed for the whole burst
   always_ff @(posedge clk)
   begin
      if (miss)
         fill_way_q <= victim_way;
   end

   ////////////////////////////////////////
   // Tag and rank writes
   ////////////////////////////////////////

   // Boot clears every way, a miss claims the victim
   always_comb
   begin
      tag_we = '0;
      tag_wr = '0;
      if (in_boot)
         tag_we = '1;
      else if (miss)
      begin
         tag_we[victim_way] = 1'b1;
         tag_wr.valid       = 1'b1;
         tag_wr.tag         = req_addr[`ICACHE_AW-1:`ICACHE_TAG_LSB];
      end
   end

   assign rank_we = in_boot || rsp_valid;

   // Seed ranks with the way number at boot
   always_comb
   begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
         rank_wr[w] = in_boot ? icache_pkg::lru_rank_t'(w) : next_ranks[w];
   end

   assign wr_set = in_boot ? boot_set_q :
                   req_addr[`ICACHE_TAG_LSB-1:`ICACHE_P_LINE];

   // Beats land in word order
   assign data_wr_en   = (state_q == icache_pkg::S_FILL) && bus_b.valid;
   assign data_wr_way  = fill_way_q;
   assign data_wr_word = beat_q;

   ////////////////////////////////////////
   // Fetch side and bus request
   ////////////////////////////////////////

   assign fetch_ready = in_idle && !(req_pending && !hit);
   assign rsp_valid   = in_idle && req_pending && hit;
   // Reread the held request once the line is in place
   assign lookup_en   = (state_q == icache_pkg::S_RETAG);

   always_comb
   begin
      bus_a.valid = bus_req_q;
      bus_a.addr  = {req_addr[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}};
      bus_a.len   = '1;
   end

endmodule

/* source/icache_top.sv */
// Instruction cache top level with the fetch request stage and block wiring

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_top (
   input  logic                    clk,
   input  logic                    ibus_rst_n,
   // Fetch port
   input  icache_pkg::fetch_req_t  fetch,
   output logic                    fetch_ready,
   output logic                    rsp_valid,
   output icache_pkg::word_t       rsp_data,
   // Instruction bus
   output icache_pkg::bus_req_t    bus_a,
   input  logic                    bus_a_ready,
   input  icache_pkg::bus_beat_t   bus_b
);

   logic                                        accept;
   logic                                        req_pending_q;
   icache_pkg::paddr_t                          req_addr_q;
   icache_pkg::paddr_t                          lookup_addr;
   logic                                        rd_en;
   logic                                        lookup_en;
   icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]   rd_tags;
   icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]   rd_ranks;
   icache_pkg::word_t      [`ICACHE_WAYS-1:0]   rd_data;
   logic                                        hit;
   icache_pkg::way_idx_t                        hit_way;
   icache_pkg::way_idx_t                        victim_way;
   icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]   next_ranks;
   icache_pkg::way_vec_t                        tag_we;
   icache_pkg::tag_entry_t                      tag_wr;
   logic                                        rank_we;
   icache_pkg::lru_rank_t  [`ICACHE_WAYS-1:0]   rank_wr;
   icache_pkg::set_idx_t                        wr_set;
   logic                                        data_wr_en;
   icache_pkg::way_idx_t                        data_wr_way;
   icache_pkg::beat_cnt_t                       data_wr_word;

   assign accept = fetch.valid && fetch_ready;

   ////////////////////////////////////////
   // Request stage
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
         req_pending_q <= 1'b0;
      else if (accept)
         req_pending_q <= 1'b1;
      else if (rsp_valid)
         req_pending_q <= 1'b0;
   end

   // Held through the whole miss
   always_ff @(posedge clk)
   begin
      if (accept)
         req_addr_q <= fetch.addr;
   end

   // New address when the port is open, held address on retag
   assign lookup_addr = fetch_ready ? fetch.addr : req_addr_q;
   assign rd_en       = accept || lookup_en;

   icache_tag_store u_tag_store (
      .clk        (clk),
      .ibus_rst_n (ibus_rst_n),
      .rd_en      (rd_en),
      .rd_set     (lookup_addr[`ICACHE_TAG_LSB-1:`ICACHE_P_LINE]),
      .rd_tags    (rd_tags),
      .rd_ranks   (rd_ranks),
      .tag_we     (tag_we),
      .tag_wr     (tag_wr),
      .rank_we    (rank_we),
      .rank_wr    (rank_wr),
      .wr_set     (wr_set)
   );

   icache_way_select u_way_select (
      .req_addr   (req_addr_q),
      .tags       (rd_tags),
      .ranks      (rd_ranks),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .next_ranks (next_ranks)
   );

   icache_data_store u_data_store (
      .clk        (clk),
      .rd_en      (rd_en),
      .rd_set     (lookup_addr[`ICACHE_TAG_LSB-1:`ICACHE_P_LINE]),
      .rd_word    (lookup_addr[`ICACHE_P_LINE-1:`ICACHE_WORD_LOG2]),
      .rd_data    (rd_data),
      .wr_en      (data_wr_en),
      .wr_way     (data_wr_way),
      .wr_set     (wr_set),
      .wr_word    (data_wr_word),
      .wr_data    (bus_b.data)
   );

   icache_refill u_refill (
      .clk          (clk),
      .ibus_rst_n   (ibus_rst_n),
      .req_pending  (req_pending_q),
      .req_addr     (req_addr_q),
      .hit          (hit),
      .victim_way   (victim_way),
      .next_ranks   (next_ranks),
      .fetch_ready  (fetch_ready),
      .rsp_valid    (rsp_valid),
      .lookup_en    (lookup_en),
      .tag_we       (tag_we),
      .tag_wr       (tag_wr),
      .rank_we      (rank_we),
      .rank_wr      (rank_wr),
      .wr_set       (wr_set),
      .data_wr_en   (data_wr_en),
      .data_wr_way  (data_wr_way),
      .data_wr_word (data_wr_word),
      .bus_a        (bus_a),
      .bus_a_ready  (bus_a_ready),
      .bus_b        (bus_b)
   );

   // Word of the matching way
   assign rsp_data = rd_data[hit_way];

endmodule

/* tests/icache_checker.sv */
// Instruction cache protocol assertions for the bus request and the fetch port

`timescale 1ns/1ps

module icache_checker (
   input  logic                    clk,
   input  logic                    ibus_rst_n,
   input  icache_pkg::fetch_req_t  fetch,
   input  logic                    fetch_ready,
   input  logic                    rsp_valid,
   input  icache_pkg::bus_req_t    bus_a,
   input  logic                    bus_a_ready
);

   logic seen_accept;

   // Set by the first accepted fetch after reset
   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
         seen_accept <= 1'b0;
      else if (fetch.valid && fetch_ready)
         seen_accept <= 1'b1;
   end

   ////////////////////////////////////////
   // Bus request channel
   ////////////////////////////////////////

   // Request holds its address and length until the bus takes it
   bus_a_stable: assert property (
      @(posedge clk) disable iff (!ibus_rst_n)
      bus_a.valid && !bus_a_ready |=> bus_a.valid && $stable(bus_a)
   )
   else
      $error("bus_a changed or dropped before bus_a_ready was seen");

   ////////////////////////////////////////
   // Fetch port
   ////////////////////////////////////////

   // No response can exist before anything was accepted
   rsp_needs_accept: assert property (
      @(posedge clk) disable iff (!ibus_rst_n)
      !seen_accept |-> !rsp_valid
   )
   else
      $error("rsp_valid went high before any fetch was accepted");

   // The port is closed for the whole refill
   stall_during_refill: assert property (
      @(posedge clk) disable iff (!ibus_rst_n)
      !(bus_a.valid && fetch_ready)
   )
   else
      $error("fetch_ready is high while a bus request is open");

endmodule

/* tests/icache_tb.sv */
// Instruction cache testbench with a memory model, a reference LRU cache and random fetches

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_tb;

   localparam int HIT_RUN        = 16;
   localparam int LRU_LINES      = 5;
   localparam int RAND_REQS      = 400;
   localparam int TOTAL_REQS     = 2 + HIT_RUN + 2 * LRU_LINES + RAND_REQS;
   localparam int TIMEOUT_CYCLES = 20 * (TOTAL_REQS * 12 + 32);

   logic                     clk;
   logic                     ibus_rst_n;
   icache_pkg::fetch_req_t   fetch;
   logic                     fetch_ready;
   logic                     rsp_valid;
   icache_pkg::word_t        rsp_data;
   icache_pkg::bus_req_t     bus_a;
   logic                     bus_a_ready;
   icache_pkg::bus_beat_t    bus_b;

   // Reference cache state per set and way
   logic                     m_valid [`ICACHE_SETS][`ICACHE_WAYS];
   icache_pkg::tag_addr_t    m_tag   [`ICACHE_SETS][`ICACHE_WAYS];
   icache_pkg::lru_rank_t    m_rank  [`ICACHE_SETS][`ICACHE_WAYS];

   // Expected responses, and line addresses of predicted misses
   icache_pkg::paddr_t       exp_q  [$];
   icache_pkg::paddr_t       line_q [$];

   logic                     hit_due;
   logic                     accepted;
   logic                     req_seen;
   int                       ready_delay;
   icache_pkg::paddr_t       fill_addr;
   int                       beats_left;
   int                       beat_idx;
   int                       cycle_cnt = 0;

   icache_top uut (
      .clk         (clk),
      .ibus_rst_n  (ibus_rst_n),
      .fetch       (fetch),
      .fetch_ready (fetch_ready),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data),
      .bus_a       (bus_a),
      .bus_a_ready (bus_a_ready),
      .bus_b       (bus_b)
   );

   bind icache_top icache_checker u_checker (
      .clk         (clk),
      .ibus_rst_n  (ibus_rst_n),
      .fetch       (fetch),
      .fetch_ready (fetch_ready),
      .rsp_valid   (rsp_valid),
      .bus_a       (bus_a),
      .bus_a_ready (bus_a_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES)
         fail_now($sformatf("Timeout after %0d cycles, the tests did not finish", cycle_cnt));
   end

   ////////////////////////////////////////
   // Error reporting and compares
   ////////////////////////////////////////

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_word(input string name, input icache_pkg::word_t got,
                             input icache_pkg::word_t exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic check_addr(input string name, input icache_pkg::paddr_t got,
                             input icache_pkg::paddr_t exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic check_len(input string name, input icache_pkg::beat_cnt_t got,
                            input icache_pkg::beat_cnt_t exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                            $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                            $time, name, got, exp));
   endtask

   ////////////////////////////////////////
   // Memory and reference cache
   ////////////////////////////////////////

   // Word stored at an address, mixed from every address bit
   function automatic icache_pkg::word_t mem_word(input icache_pkg::paddr_t addr);
      icache_pkg::word_t mix;
      mix = addr ^ (addr >> 15);
      mix = mix * 32'h2C1B_3C6D;
      return mix ^ (mix >> 12) ^ 32'hA5A5_0000;
   endfunction

   function automatic icache_pkg::paddr_t make_addr(input icache_pkg::tag_addr_t tag,
                                                    input icache_pkg::set_idx_t set,
                                                    input icache_pkg::beat_cnt_t word);
      return {tag, set, word, {`ICACHE_WORD_LOG2{1'b0}}};
   endfunction

   function automatic icache_pkg::paddr_t line_of(input icache_pkg::paddr_t addr);
      return {addr[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}};
   endfunction

   task automatic model_reset();
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
         for (int w = 0; w < `ICACHE_WAYS; w++)
         begin
            m_valid[s][w] = 1'b0;
            m_tag[s][w]   = '0;
            m_rank[s][w]  = icache_pkg::lru_rank_t'(w);
         end
      end
   endtask

   // Look up one address, refill on a miss, then make the way most recent
   task automatic model_access(input icache_pkg::paddr_t addr, output logic hit);
      icache_pkg::set_idx_t  s;
      icache_pkg::tag_addr_t t;
      icache_pkg::lru_rank_t old_rank;
      int                    way;
      s   = addr[`ICACHE_TAG_LSB-1:`ICACHE_P_LINE];
      t   = addr[`ICACHE_AW-1:`ICACHE_TAG_LSB];
      way = -1;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (m_valid[s][w] && m_tag[s][w] == t)
            way = w;
      end
      hit = (way >= 0);
      if (!hit)
      begin
         for (int w = 0; w < `ICACHE_WAYS; w++)
         begin
            if (m_rank[s][w] == 0)
               way = w;
         end
         m_valid[s][way] = 1'b1;
         m_tag[s][way]   = t;
      end
      old_rank = m_rank[s][way];
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         if (w == way)
            m_rank[s][w] = '1;
         else if (m_rank[s][w] > old_rank)
            m_rank[s][w] = icache_pkg::lru_rank_t'(m_rank[s][w] - 1);
      end
   endtask

   ////////////////////////////////////////
   // Per cycle sampling and bus driving
   ////////////////////////////////////////

   // Runs mid cycle, sees what the next rising edge will do
   task automatic observe();
      icache_pkg::paddr_t exp_addr;
      logic               hit;
      if (hit_due)
         check_flag("rsp_valid", rsp_valid, 1'b1);
      hit_due = 1'b0;
      if (rsp_valid)
      begin
         if (exp_q.size() == 0)
            fail_now("A response came with no fetch outstanding");
         check_flag("refill request seen before response", line_q.size() == 0, 1'b1);
         exp_addr = exp_q.pop_front();
         check_word("rsp_data", rsp_data, mem_word(exp_addr));
      end
      accepted = 1'b0;
      if (fetch.valid && fetch_ready)
      begin
         accepted = 1'b1;
         model_access(fetch.addr, hit);
         exp_q.push_back(fetch.addr);
         if (hit)
            hit_due = 1'b1;
         else
            line_q.push_back(line_of(fetch.addr));
      end
      if (bus_a.valid && bus_a_ready)
      begin
         if (line_q.size() == 0)
            fail_now("A bus request came although the model predicted no miss");
         check_addr("bus_a.addr", bus_a.addr, line_q[0]);
         check_len("bus_a.len", bus_a.len, icache_pkg::beat_cnt_t'(3));
         fill_addr  = line_q.pop_front();
         beats_left = `ICACHE_WORDS;
         beat_idx   = 0;
         req_seen   = 1'b0;
      end
      if (bus_b.valid)
      begin
         beats_left--;
         beat_idx++;
      end
   endtask

   // Request accepted after 0 to 3 cycles, beats with random gaps
   task automatic drive_bus();
      bus_a_ready = 1'b0;
      bus_b       = '0;
      if (bus_a.valid)
      begin
         if (!req_seen)
         begin
            req_seen    = 1'b1;
            ready_delay = $urandom_range(3, 0);
         end
         if (ready_delay == 0)
            bus_a_ready = 1'b1;
         else
            ready_delay--;
      end
      else if (beats_left > 0 && $urandom_range(2, 0) != 0)
      begin
         bus_b.valid = 1'b1;
         bus_b.data  = mem_word(fill_addr + icache_pkg::paddr_t'(beat_idx * 4));
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      observe();
      @(posedge clk);
      #1;
      drive_bus();
   endtask

   task automatic issue(input icache_pkg::paddr_t addr, output int waited);
      fetch.valid = 1'b1;
      fetch.addr  = addr;
      waited      = 0;
      accepted    = 1'b0;
      while (!accepted)
      begin
         next_cycle();
         waited++;
      end
      fetch.valid = 1'b0;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0 || beats_left != 0)
         next_cycle();
   endtask

   ////////////////////////////////////////
   // Test phases
   ////////////////////////////////////////

   // Port and bus stay quiet through the tag sweep
   task automatic check_boot();
      for (int i = 0; i < `ICACHE_SETS; i++)
      begin
         @(negedge clk);
         check_flag("fetch_ready", fetch_ready, 1'b0);
         check_flag("bus_a.valid", bus_a.valid, 1'b0);
         check_flag("rsp_valid", rsp_valid, 1'b0);
         @(posedge clk);
         #1;
      end
      @(negedge clk);
      check_flag("fetch_ready", fetch_ready, 1'b1);
      @(posedge clk);
      #1;
   endtask

   task automatic run_hit_streak();
      icache_pkg::paddr_t base [2];
      int                 waited;
      base[0] = make_addr(24'h000123, 4'd1, 2'd0);
      base[1] = make_addr(24'h000456, 4'd2, 2'd0);
      issue(base[0], waited);
      issue(base[1], waited);
      wait_idle();
      for (int i = 0; i < HIT_RUN; i++)
      begin
         issue(base[i % 2] | icache_pkg::paddr_t'($urandom_range(3, 0) * 4), waited);
         check_flag("accepted in one cycle", waited == 1, 1'b1);
      end
      wait_idle();
   endtask

   task automatic shuffle(ref int order [LRU_LINES]);
      int j;
      int tmp;
      for (int i = LRU_LINES - 1; i > 0; i--)
      begin
         j        = $urandom_range(i, 0);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
   endtask

   // Five lines share one set, the refetches must follow the model's LRU order
   task automatic run_lru_set();
      icache_pkg::tag_addr_t tags  [LRU_LINES];
      int                    order [LRU_LINES];
      int                    waited;
      for (int i = 0; i < LRU_LINES; i++)
      begin
         tags[i]  = icache_pkg::tag_addr_t'(32'h40 + i * 7);
         order[i] = i;
      end
      for (int pass = 0; pass < 2; pass++)
      begin
         shuffle(order);
         for (int i = 0; i < LRU_LINES; i++)
            issue(make_addr(tags[order[i]], 4'd5,
                            icache_pkg::beat_cnt_t'($urandom_range(3, 0))), waited);
      end
      wait_idle();
   endtask

   task automatic run_random();
      icache_pkg::paddr_t addr;
      int                 waited;
      for (int i = 0; i < RAND_REQS; i++)
      begin
         addr = make_addr(icache_pkg::tag_addr_t'($urandom_range(5, 0)),
                          icache_pkg::set_idx_t'($urandom_range(7, 0)),
                          icache_pkg::beat_cnt_t'($urandom_range(3, 0)));
         if ($urandom_range(3, 0) == 0)
            next_cycle();
         issue(addr, waited);
      end
      wait_idle();
   endtask

   initial
   begin
      void'($urandom(28205));
      ibus_rst_n  = 1'b0;
      fetch       = '0;
      bus_a_ready = 1'b0;
      bus_b       = '0;
      hit_due     = 1'b0;
      accepted    = 1'b0;
      req_seen    = 1'b0;
      ready_delay = 0;
      fill_addr   = '0;
      beats_left  = 0;
      beat_idx    = 0;
      model_reset();
      repeat (5) @(posedge clk);
      #1;
      ibus_rst_n = 1'b1;

      check_boot();
      run_hit_streak();
      run_lru_set();
      run_random();

      // A few idle cycles to catch stray requests or responses
      repeat (8) next_cycle();
      if (exp_q.size() != 0 || line_q.size() != 0 || beats_left != 0)
         fail_now("Fetches or refills were still outstanding at the end of the run");
      else
      begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

/* vlog.f */
+incdir+source
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_way_select.sv
source/icache_data_store.sv
source/icache_refill.sv
source/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
   -f vlog.f -o icache_sim \
   && ./obj_dir/icache_sim 2>&1 | tee /dev/stderr | grep "^Simulation passed$" > /dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
